/* Bender.yml */
package:
  name: pio

sources:
  - logic/pio_pkg.sv
  - logic/pio_fifo.sv
  - logic/pio_control.sv
  - logic/pio_machine.sv
  - logic/pio_pin_merge.sv
  - logic/pio.sv
  - target: test
    files:
      - verification/pio_tb.sv

/* build.f */
logic/pio_pkg.sv
logic/pio_fifo.sv
logic/pio_control.sv
logic/pio_machine.sv
logic/pio_pin_merge.sv
logic/pio.sv
verification/pio_tb.sv

/* logic/pio.sv */
`timescale 1ns/1ns

module pio (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [pio_pkg::mindex_w-1:0] mindex,
  input  logic [31:0]                  din,
  input  logic [4:0]                   index,
  input  logic [3:0]                   action,
  output logic [31:0]                  dout,
  input  logic [31:0]                  gpio_in,
  output logic [31:0]                  gpio_out,
  output logic [31:0]                  gpio_dir,
  output logic                         irq0,
  output logic                         irq1
);

  pio_pkg::pc_t                     pc [pio_pkg::num_machines];
  pio_pkg::instr_t                  instr [pio_pkg::num_machines];
  pio_pkg::machine_cfg_t            cfg [pio_pkg::num_machines];
  pio_pkg::pin_write_t              pin_req [pio_pkg::num_machines];
  pio_pkg::rx_word_t                rx_word [pio_pkg::num_machines];
  pio_pkg::rx_word_t                rx_head [pio_pkg::num_machines];
  logic [31:0]                      tx_data [pio_pkg::num_machines];
  logic [pio_pkg::num_machines-1:0] en;
  logic [pio_pkg::num_machines-1:0] tx_push;
  logic [pio_pkg::num_machines-1:0] tx_pop;
  logic [pio_pkg::num_machines-1:0] tx_empty;
  logic [pio_pkg::num_machines-1:0] rx_push;
  logic [pio_pkg::num_machines-1:0] rx_pull;
  logic [pio_pkg::num_machines-1:0] rx_full;
  logic [pio_pkg::num_machines-1:0] rx_empty;
  logic [pio_pkg::num_machines-1:0] stalled;

  pio_control u_control (
    .clk     (clk),
    .reset   (reset),
    .action  (action),
    .mindex  (mindex),
    .index   (index),
    .din     (din),
    .pc      (pc),
    .instr   (instr),
    .cfg     (cfg),
    .en      (en),
    .tx_push (tx_push),
    .rx_pull (rx_pull)
  );

  for (genvar m = 0; m < pio_pkg::num_machines; m++) begin : g_machine
    pio_fifo #(
      .payload_t (logic [31:0])
    ) u_tx_fifo (
      .clk   (clk),
      .reset (reset),
      .push  (tx_push[m]),
      .pop   (tx_pop[m]),
      .wdata (din),
      .rdata (tx_data[m]),
      .full  (),
      .empty (tx_empty[m])
    );

    pio_machine u_machine (
      .clk      (clk),
      .reset    (reset),
      .en       (en[m]),
      .cfg      (cfg[m]),
      .instr    (instr[m]),
      .gpio_in  (gpio_in),
      .tx_data  (tx_data[m]),
      .tx_empty (tx_empty[m]),
      .rx_full  (rx_full[m]),
      .pc       (pc[m]),
      .tx_pop   (tx_pop[m]),
      .rx_push  (rx_push[m]),
      .rx_data  (rx_word[m]),
      .pin_req  (pin_req[m]),
      .stalled  (stalled[m])
    );

    pio_fifo #(
      .payload_t (pio_pkg::rx_word_t)
    ) u_rx_fifo (
      .clk   (clk),
      .reset (reset),
      .push  (rx_push[m]),
      .pop   (rx_pull[m]),
      .wdata (rx_word[m]),
      .rdata (rx_head[m]),
      .full  (rx_full[m]),
      .empty (rx_empty[m])
    );
  end

  pio_pin_merge u_pin_merge (
    .clk      (clk),
    .reset    (reset),
    .pin_req  (pin_req),
    .rx_empty (rx_empty),
    .stalled  (stalled),
    .gpio_out (gpio_out),
    .gpio_dir (gpio_dir),
    .irq0     (irq0),
    .irq1     (irq1)
  );

  assign dout = rx_head[mindex].data; // Head of the selected receive FIFO

endmodule

/* logic/pio_control.sv */
`timescale 1ns/1ns

module pio_control (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [3:0]                           action,
  input  logic [pio_pkg::mindex_w-1:0]         mindex,
  input  logic [4:0]                           index,
  input  logic [31:0]                          din,
  input  pio_pkg::pc_t                         pc [pio_pkg::num_machines],
  output pio_pkg::instr_t                      instr [pio_pkg::num_machines],
  output pio_pkg::machine_cfg_t                cfg [pio_pkg::num_machines],
  output logic [pio_pkg::num_machines-1:0]     en,
  output logic [pio_pkg::num_machines-1:0]     tx_push,
  output logic [pio_pkg::num_machines-1:0]     rx_pull
);

  // Shared program store
  pio_pkg::instr_t imem [pio_pkg::instr_depth];

  always_ff @(posedge clk) begin
    if (action == pio_pkg::act_instr) begin
      imem[index] <= din[15:0];
    end
  end

  // Each machine fetches at its own pc
  always_comb begin
    for (int m = 0; m < pio_pkg::num_machines; m++) begin
      instr[m] = imem[pc[m]];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      en <= '0;
      for (int m = 0; m < pio_pkg::num_machines; m++) begin
        cfg[m].wrap_start <= '0;
        cfg[m].wrap_end <= '0;
        cfg[m].pin_base <= '0;
        cfg[m].div <= 24'd1;
      end
    end else begin
      case (action)
        pio_pkg::act_wrap: begin
          cfg[mindex].wrap_end <= index;
          cfg[mindex].wrap_start <= din[4:0];
        end
        pio_pkg::act_pins: begin
          cfg[mindex].pin_base <= din[4:0];
        end
        pio_pkg::act_enable: begin
          en <= din[pio_pkg::num_machines-1:0];
        end
        pio_pkg::act_div: begin
          cfg[mindex].div <= din[23:0];
        end
        default: begin
        end
      endcase
    end
  end

  // FIFO strobes go straight through so din is still valid
  always_comb begin
    tx_push = '0;
    rx_pull = '0;
    tx_push[mindex] = (action == pio_pkg::act_push);
    rx_pull[mindex] = (action == pio_pkg::act_pull);
  end

  mindex_known: assert property (@(posedge clk) disable iff (reset)
    (action != 4'd0) |-> !$isunknown(mindex))
    else $error("mindex unknown during host action %0d", action);

endmodule

/* logic/pio_fifo.sv */
`timescale 1ns/1ns

module pio_fifo #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  logic     pop,
  input  payload_t wdata,
  output payload_t rdata,
  output logic     full,
  output logic     empty
);

  payload_t                         mem [pio_pkg::fifo_depth];
  logic [pio_pkg::fifo_ptr_w-1:0]   wr_ptr;
  logic [pio_pkg::fifo_ptr_w-1:0]   rd_ptr;
  logic [pio_pkg::fifo_ptr_w:0]     count;
  logic                             do_push;
  logic                             do_pop;

  assign full = (count == (pio_pkg::fifo_ptr_w + 1)'(pio_pkg::fifo_depth));
  assign empty = (count == '0);
  assign do_push = push && !full; // Dropped when full
  assign do_pop = pop && !empty;
  assign rdata = mem[rd_ptr];     // Head shown without a pop

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: begin
        end
      endcase
    end
  end

  no_push_full: assert property (@(posedge clk) disable iff (reset) full |-> !push)
    else $warning("push to full FIFO dropped");
  no_pop_empty: assert property (@(posedge clk) disable iff (reset) empty |-> !pop)
    else $warning("pop from empty FIFO ignored");

endmodule

/* logic/pio_machine.sv */
`timescale 1ns/1ns

module pio_machine (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  en,
  input  pio_pkg::machine_cfg_t cfg,
  input  pio_pkg::instr_t       instr,
  input  logic [31:0]           gpio_in,
  input  logic [31:0]           tx_data,
  input  logic                  tx_empty,
  input  logic                  rx_full,
  output pio_pkg::pc_t          pc,
  output logic                  tx_pop,
  output logic                  rx_push,
  output pio_pkg::rx_word_t     rx_data,
  output pio_pkg::pin_write_t   pin_req,
  output logic                  stalled
);

  logic [23:0] div_cnt;
  logic [23:0] div_last;
  logic        tick;
  logic [31:0] x;
  logic [31:0] osr;
  logic [31:0] isr;
  logic [5:0]  isr_count;
  logic [6:0]  in_sum;
  logic [5:0]  nbits;
  logic [31:0] field_mask;
  logic [31:0] pins_in;
  logic        is_pull;
  logic        is_push;
  logic        hold;
  logic        jump;

  function automatic logic [31:0] rotl(input logic [31:0] v, input logic [4:0] s);
    logic [63:0] t;
    t = {v, v} << s;
    return t[63:32];
  endfunction

  function automatic logic [31:0] rotr(input logic [31:0] v, input logic [4:0] s);
    logic [63:0] t;
    t = {v, v} >> s;
    return t[31:0];
  endfunction

  // Divider of 0 or 1 ticks every cycle
  assign div_last = (cfg.div > 24'd1) ? cfg.div - 24'd1 : 24'd0;
  assign tick = en && (div_cnt >= div_last);

  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt <= '0;
    end else if (!en || tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 24'd1;
    end
  end

  assign nbits = (instr.data == 5'd0) ? 6'd32 : {1'b0, instr.data}; // Count 0 means 32
  assign field_mask = 32'((33'd1 << nbits) - 33'd1);
  assign pins_in = rotr(gpio_in, cfg.pin_base) & field_mask;
  assign in_sum = {1'b0, isr_count} + {1'b0, nbits};

  assign is_pull = (instr.opcode == pio_pkg::op_pushpull) && (instr.cond == pio_pkg::pp_pull);
  assign is_push = (instr.opcode == pio_pkg::op_pushpull) && (instr.cond == pio_pkg::pp_push);
  assign hold = (is_pull && tx_empty) || (is_push && rx_full);
  assign tx_pop = tick && is_pull && !tx_empty;
  assign rx_push = tick && is_push && !rx_full;
  assign stalled = en && is_pull && tx_empty;
  assign rx_data = '{data: isr, count: isr_count};

  always_comb begin
    jump = 1'b0;
    if (instr.opcode == pio_pkg::op_jmp) begin
      case (instr.cond)
        pio_pkg::jmp_always: jump = 1'b1;
        pio_pkg::jmp_x_dec: jump = (x != 32'd0);
        pio_pkg::jmp_pin: jump = gpio_in[cfg.pin_base];
        default: jump = 1'b0;
      endcase
    end
  end

  // Pin request lives only in the execute cycle
  always_comb begin
    pin_req = '0;
    if (tick) begin
      case (instr.opcode)
        pio_pkg::op_out: begin
          pin_req.value = rotl(osr & field_mask, cfg.pin_base);
          pin_req.mask = rotl(field_mask, cfg.pin_base);
        end
        pio_pkg::op_set: begin
          if (instr.cond == pio_pkg::set_pins) begin
            pin_req.value = rotl({27'd0, instr.data}, cfg.pin_base);
            pin_req.mask = rotl(32'h1f, cfg.pin_base);
          end else if (instr.cond == pio_pkg::set_pindirs) begin
            pin_req.dir_value = rotl({27'd0, instr.data}, cfg.pin_base);
            pin_req.dir_mask = rotl(32'h1f, cfg.pin_base);
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
      x <= '0;
      osr <= '0;
      isr <= '0;
      isr_count <= '0;
    end else if (!en) begin
      pc <= cfg.wrap_start;
    end else if (tick) begin
      case (instr.opcode)
        pio_pkg::op_jmp: begin
          if (instr.cond == pio_pkg::jmp_x_dec) begin
            x <= x - 32'd1;
          end
        end
        pio_pkg::op_in: begin
          isr <= (isr << nbits) | pins_in;
          isr_count <= (in_sum > 7'd32) ? 6'd32 : in_sum[5:0];
        end
        pio_pkg::op_out: begin
          osr <= osr >> nbits;
        end
        pio_pkg::op_pushpull: begin
          if (tx_pop) begin
            osr <= tx_data;
          end
          if (rx_push) begin
            isr <= '0;
            isr_count <= '0;
          end
        end
        pio_pkg::op_set: begin
          if (instr.cond == pio_pkg::set_x) begin
            x <= {27'd0, instr.data};
          end
        end
        default: begin
        end
      endcase

      if (jump) begin
        pc <= instr.data;
      end else if (hold) begin
        pc <= pc;                      // Retry on the next tick
      end else if (pc == cfg.wrap_end) begin
        pc <= cfg.wrap_start;
      end else begin
        pc <= pc + 5'd1;
      end
    end
  end

  pc_moves_on_tick: assert property (@(posedge clk) disable iff (reset)
    (en && !tick) |=> $stable(pc))
    else $error("pc changed between ticks");

endmodule

/* logic/pio_pin_merge.sv */
`timescale 1ns/1ns

module pio_pin_merge (
  input  logic                             clk,
  input  logic                             reset,
  input  pio_pkg::pin_write_t              pin_req [pio_pkg::num_machines],
  input  logic [pio_pkg::num_machines-1:0] rx_empty,
  input  logic [pio_pkg::num_machines-1:0] stalled,
  output logic [31:0]                      gpio_out,
  output logic [31:0]                      gpio_dir,
  output logic                             irq0,
  output logic                             irq1
);

  logic [31:0] out_next;
  logic [31:0] dir_next;

  // Later machines overwrite earlier ones on shared bits
  always_comb begin
    out_next = gpio_out;
    dir_next = gpio_dir;
    for (int m = 0; m < pio_pkg::num_machines; m++) begin
      out_next = (out_next & ~pin_req[m].mask) | (pin_req[m].value & pin_req[m].mask);
      dir_next = (dir_next & ~pin_req[m].dir_mask) |
                 (pin_req[m].dir_value & pin_req[m].dir_mask);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      gpio_out <= '0;
      gpio_dir <= '0;
      irq0 <= 1'b0;
      irq1 <= 1'b0;
    end else begin
      gpio_out <= out_next;
      gpio_dir <= dir_next;
      irq0 <= ~&rx_empty; // Some receive FIFO holds data
      irq1 <= |stalled;   // Some machine starved on PULL
    end
  end

endmodule

/* logic/pio_pkg.sv */
package pio_pkg;

  localparam int num_machines = 4;
  localparam int mindex_w = $clog2(num_machines);
  localparam int instr_depth = 32;
  localparam int fifo_depth = 4; // Power of two so pointers wrap freely
  localparam int fifo_ptr_w = $clog2(fifo_depth);

  typedef logic [4:0] pc_t;

  // Opcodes, top three bits of an instruction
  localparam logic [2:0] op_jmp = 3'b000;
  localparam logic [2:0] op_in = 3'b010;
  localparam logic [2:0] op_out = 3'b011;
  localparam logic [2:0] op_pushpull = 3'b100;
  localparam logic [2:0] op_set = 3'b111;

  // JMP conditions
  localparam logic [2:0] jmp_always = 3'b000;
  localparam logic [2:0] jmp_x_dec = 3'b010; // Taken on X non-zero with X decremented
  localparam logic [2:0] jmp_pin = 3'b110;   // Tests gpio_in at pin_base

  // PUSH or PULL select
  localparam logic [2:0] pp_push = 3'b000;
  localparam logic [2:0] pp_pull = 3'b100;

  // SET destinations
  localparam logic [2:0] set_pins = 3'b000;
  localparam logic [2:0] set_x = 3'b001;
  localparam logic [2:0] set_pindirs = 3'b100;

  // Host action codes
  localparam logic [3:0] act_instr = 4'd1;
  localparam logic [3:0] act_wrap = 4'd2;
  localparam logic [3:0] act_pull = 4'd3;
  localparam logic [3:0] act_push = 4'd4;
  localparam logic [3:0] act_pins = 4'd5;
  localparam logic [3:0] act_enable = 4'd6;
  localparam logic [3:0] act_div = 4'd7;

  typedef struct packed {
    logic [2:0] opcode;
    logic [2:0] cond;     // Condition or destination
    logic [4:0] data;     // Jump target, SET value or bit count
    logic [4:0] reserved;
  } instr_t;

  typedef struct packed {
    pc_t         wrap_start;
    pc_t         wrap_end;
    logic [4:0]  pin_base;
    logic [23:0] div;
  } machine_cfg_t;

  typedef struct packed {
    logic [31:0] value;
    logic [31:0] mask;
    logic [31:0] dir_value;
    logic [31:0] dir_mask;
  } pin_write_t;

  typedef struct packed {
    logic [31:0] data;
    logic [5:0]  count; // Bits shifted in before the push
  } rx_word_t;

endpackage

/* verification/pio_tb.sv */
`timescale 1ns/1ns

module pio_tb;

  localparam int timeout_cycles = 5 * 8 * 100; // Five tests at divider up to 8 with wide margin

  logic                         clk;
  logic                         reset;
  logic [pio_pkg::mindex_w-1:0] mindex;
  logic [31:0]                  din;
  logic [4:0]                   index;
  logic [3:0]                   action;
  logic [31:0]                  dout;
  logic [31:0]                  gpio_in;
  logic [31:0]                  gpio_out;
  logic [31:0]                  gpio_dir;
  logic                         irq0;
  logic                         irq1;

  int                errors;
  int                cycles;
  logic [31:0]       lfsr;
  logic              enabled_once;
  logic              set_phase;
  logic [4:0]        set_val;
  logic              out_phase;
  logic [7:0]        out_bytes [3];
  logic [7:0]        out_prev;
  int                out_idx;
  pio_pkg::rx_word_t rx_model;
  logic              jmp_phase;
  logic              toggle_prev;
  int                toggles;
  logic              ovr_phase;
  logic [4:0]        ovr_pre;
  logic [4:0]        ovr_k;

  pio u_dut (
    .clk      (clk),
    .reset    (reset),
    .mindex   (mindex),
    .din      (din),
    .index    (index),
    .action   (action),
    .dout     (dout),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_dir (gpio_dir),
    .irq0     (irq0),
    .irq1     (irq1)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles, a wait on the DUT never ended (%0d errors)",
               cycles, errors);
      $display("tests failed");
      $finish;
    end
  end

  // Byte order and toggle models
  always @(posedge clk) begin
    toggle_prev <= gpio_out[20];
    if (!out_phase) begin
      out_prev <= gpio_out[7:0];
      out_idx <= 0;
    end else if (gpio_out[7:0] != out_prev) begin
      out_prev <= gpio_out[7:0];
      out_idx <= out_idx + 1;
    end
    if (!jmp_phase) begin
      toggles <= 0;
    end else if (gpio_out[20] && !toggle_prev) begin
      toggles <= toggles + 1; // Rising edge of the loop pin
    end
  end

  quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
    !enabled_once |-> ({gpio_out, gpio_dir, irq0, irq1} == '0))
    else begin
      errors++;
      $display("FAIL %0t {gpio_out,gpio_dir,irq0,irq1} expected 0 got %h", $time,
               $sampled({gpio_out, gpio_dir, irq0, irq1}));
    end

  set_dirs: assert property (@(posedge clk) disable iff (reset)
    (set_phase && gpio_dir[8:4] != 5'd0) |-> (gpio_dir[8:4] == 5'h1f))
    else begin
      errors++;
      $display("FAIL %0t gpio_dir[8:4] expected 1f got %h", $time, $sampled(gpio_dir[8:4]));
    end

  set_pins: assert property (@(posedge clk) disable iff (reset)
    (set_phase && gpio_out[8:4] != 5'd0) |-> (gpio_out[8:4] == set_val))
    else begin
      errors++;
      $display("FAIL %0t gpio_out[8:4] expected %h got %h", $time, set_val,
               $sampled(gpio_out[8:4]));
    end

  out_order: assert property (@(posedge clk) disable iff (reset)
    (out_phase && gpio_out[7:0] != out_prev) |->
      (out_idx < 3 && gpio_out[7:0] == out_bytes[out_idx]))
    else begin
      errors++;
      $display("FAIL %0t gpio_out[7:0] expected %h got %h", $time,
               ($sampled(out_idx) < 3) ? out_bytes[$sampled(out_idx)] : 8'hxx,
               $sampled(gpio_out[7:0]));
    end

  stall_after_drain: assert property (@(posedge clk) disable iff (reset)
    (out_phase && irq1) |-> (out_idx == 3))
    else begin
      errors++;
      $display("FAIL %0t irq1 expected 0 got 1 with %0d of 3 bytes out", $time,
               $sampled(out_idx));
    end

  rx_head: assert property (@(posedge clk) disable iff (reset)
    (action == pio_pkg::act_pull && mindex == 2'd2) |-> (dout == rx_model.data))
    else begin
      errors++;
      $display("FAIL %0t dout expected %h got %h", $time, rx_model.data, $sampled(dout));
    end

  marker_after_toggles: assert property (@(posedge clk) disable iff (reset)
    (jmp_phase && gpio_out[21]) |-> (toggles == 4))
    else begin
      errors++;
      $display("FAIL %0t toggles before gpio_out[21] expected 4 got %0d", $time,
               $sampled(toggles));
    end

  override_value: assert property (@(posedge clk) disable iff (reset)
    ovr_phase |-> (gpio_out[8:4] == ovr_pre || gpio_out[8:4] == ovr_k))
    else begin
      errors++;
      $display("FAIL %0t gpio_out[8:4] expected %h got %h", $time, ovr_k,
               $sampled(gpio_out[8:4]));
    end

  override_holds: assert property (@(posedge clk) disable iff (reset)
    (ovr_phase && gpio_out[8:4] == ovr_k) |=> (gpio_out[8:4] == ovr_k))
    else begin
      errors++;
      $display("FAIL %0t gpio_out[8:4] expected %h got %h", $time, ovr_k,
               $sampled(gpio_out[8:4]));
    end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic logic [15:0] make_instr(input logic [2:0] op, input logic [2:0] cond,
                                             input logic [4:0] data);
    return {op, cond, data, 5'd0};
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic host_cmd(input logic [3:0] a, input logic [pio_pkg::mindex_w-1:0] m,
                          input logic [4:0] idx, input logic [31:0] d);
    action = a;
    mindex = m;
    index = idx;
    din = d;
    next_cycle();
    action = 4'd0;
  endtask

  task automatic write_instr(input logic [4:0] addr, input logic [15:0] word);
    host_cmd(pio_pkg::act_instr, 2'd0, addr, {16'd0, word});
  endtask

  task automatic set_test();
    set_val = take_bits(5);
    if (set_val == 5'd0) begin
      set_val = 5'h15; // Zero leaves no visible change
    end
    write_instr(5'd0, make_instr(pio_pkg::op_set, pio_pkg::set_pindirs, 5'd31));
    write_instr(5'd1, make_instr(pio_pkg::op_set, pio_pkg::set_pins, set_val));
    host_cmd(pio_pkg::act_pins, 2'd0, 5'd0, 32'd4);
    host_cmd(pio_pkg::act_wrap, 2'd0, 5'd1, 32'd0);
    set_phase = 1'b1;
    enabled_once = 1'b1;
    host_cmd(pio_pkg::act_enable, 2'd0, 5'd0, 32'h1);
    while (gpio_dir[8:4] == 5'd0) begin
      next_cycle();
    end
    while (gpio_out[8:4] == 5'd0) begin
      next_cycle();
    end
    repeat (4) next_cycle();
    set_phase = 1'b0;
    host_cmd(pio_pkg::act_enable, 2'd0, 5'd0, 32'h0);
  endtask

  task automatic pull_test();
    logic [31:0] w;
    logic [7:0]  prev;
    prev = gpio_out[7:0];
    write_instr(5'd2, make_instr(pio_pkg::op_pushpull, pio_pkg::pp_pull, 5'd0));
    write_instr(5'd3, make_instr(pio_pkg::op_out, 3'd0, 5'd8));
    host_cmd(pio_pkg::act_div, 2'd1, 5'd0, 32'd3);
    host_cmd(pio_pkg::act_pins, 2'd1, 5'd0, 32'd0);
    host_cmd(pio_pkg::act_wrap, 2'd1, 5'd3, 32'd2);
    for (int i = 0; i < 3; i++) begin
      w = take_bits(32);
      if (w[7:0] == prev) begin
        w[7:0] = w[7:0] ^ 8'h01; // Each byte must show as a change
      end
      out_bytes[i] = w[7:0];
      prev = w[7:0];
      host_cmd(pio_pkg::act_push, 2'd1, 5'd0, w);
    end
    out_phase = 1'b1;
    host_cmd(pio_pkg::act_enable, 2'd0, 5'd0, 32'h2);
    while (!irq1) begin
      next_cycle();
    end
    out_phase = 1'b0;
    host_cmd(pio_pkg::act_enable, 2'd0, 5'd0, 32'h0);
  endtask

  task automatic in_test();
    gpio_in = take_bits(32);
    rx_model.data = {24'd0, gpio_in[19:12]};
    rx_model.count = 6'd8;
    write_instr(5'd4, make_instr(pio_pkg::op_in, 3'd0, 5'd8));
    write_instr(5'd5, make_instr(pio_pkg::op_pushpull, pio_pkg::pp_push, 5'd0));
    write_instr(5'd6, make_instr(pio_pkg::op_jmp, pio_pkg::jmp_always, 5'd6)); // Park
    host_cmd(pio_pkg::act_pins, 2'd2, 5'd0, 32'd12);
    host_cmd(pio_pkg::act_wrap, 2'd2, 5'd6, 32'd4);
    host_cmd(pio_pkg::act_enable, 2'd0, 5'd0, 32'h4);
    while (!irq0) begin
      next_cycle();
    end
    host_cmd(pio_pkg::act_pull, 2'd2, 5'd0, 32'd0);
    while (irq0) begin
      next_cycle();
    end
    host_cmd(pio_pkg::act_enable, 2'd0, 5'd0, 32'h0);
  endtask

  task automatic jmp_test();
    write_instr(5'd7, make_instr(pio_pkg::op_set, pio_pkg::set_x, 5'd3));
    write_instr(5'd8, make_instr(pio_pkg::op_set, pio_pkg::set_pins, 5'd1));
    write_instr(5'd9, make_instr(pio_pkg::op_set, pio_pkg::set_pins, 5'd0));
    write_instr(5'd10, make_instr(pio_pkg::op_jmp, pio_pkg::jmp_x_dec, 5'd8));
    write_instr(5'd11, make_instr(pio_pkg::op_set, pio_pkg::set_pins, 5'd2)); // Marker
    write_instr(5'd12, make_instr(pio_pkg::op_jmp, pio_pkg::jmp_always, 5'd12));
    host_cmd(pio_pkg::act_pins, 2'd3, 5'd0, 32'd20);
    host_cmd(pio_pkg::act_wrap, 2'd3, 5'd12, 32'd7);
    jmp_phase = 1'b1;
    host_cmd(pio_pkg::act_enable, 2'd0, 5'd0, 32'h8);
    while (!gpio_out[21]) begin
      next_cycle();
    end
    jmp_phase = 1'b0;
    host_cmd(pio_pkg::act_enable, 2'd0, 5'd0, 32'h0);
    // Machines 0 and 3 now fight over pins 8:4
    ovr_pre = gpio_out[8:4];
    ovr_k = set_val ^ 5'h1f;
    if (ovr_k == ovr_pre) begin
      ovr_k = ovr_k ^ 5'h10;
    end
    write_instr(5'd13, make_instr(pio_pkg::op_set, pio_pkg::set_pins, ovr_k));
    host_cmd(pio_pkg::act_pins, 2'd3, 5'd0, 32'd4);
    host_cmd(pio_pkg::act_wrap, 2'd3, 5'd13, 32'd13);
    host_cmd(pio_pkg::act_wrap, 2'd0, 5'd1, 32'd1);
    ovr_phase = 1'b1;
    host_cmd(pio_pkg::act_enable, 2'd0, 5'd0, 32'h9);
    while (gpio_out[8:4] != ovr_k) begin
      next_cycle();
    end
    repeat (8) next_cycle();
    ovr_phase = 1'b0;
    host_cmd(pio_pkg::act_enable, 2'd0, 5'd0, 32'h0);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    mindex = '0;
    din = '0;
    index = '0;
    action = 4'd0;
    gpio_in = '0;
    errors = 0;
    cycles = 0;
    lfsr = 32'd38;
    enabled_once = 1'b0;
    set_phase = 1'b0;
    set_val = '0;
    out_phase = 1'b0;
    out_prev = '0;
    out_idx = 0;
    rx_model = '0;
    jmp_phase = 1'b0;
    toggle_prev = 1'b0;
    toggles = 0;
    ovr_phase = 1'b0;
    ovr_pre = '0;
    ovr_k = '0;
    repeat (2) @(posedge clk);
    #5;
    reset = 1'b0;
    repeat (4) next_cycle(); // Outputs idle before any enable
    set_test();
    pull_test();
    in_test();
    jmp_test();
    repeat (2) next_cycle();
    $display("%0d errors after %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
